//--- Makefile
# Verilator flow for the page-fail subsystem testbench

VERILATOR ?= verilator
TOP       ?= pfTb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_TEXT ?= Test OK

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# The log decides pass or fail
sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- source/cycleDecode.sv
`include "ks10_defines.svh"

module cycleDecode
(
   input  ks10Pkg::microWord    uWord,
   input  ks10Pkg::dispatchWord dWord,
   input  ks10Pkg::vmaWord      dp,
   output logic                 pfCycle,
   output logic                 fetchCycle,
   output logic                 memClr
);

   // Bus cycle requested by this micro-instruction
   logic memEn;
   // Cycle type from each of the three sources
   logic dromCycle;
   logic dpCycle;
   logic cromCycle;

   ////////////////////////////////////////////////////////////
   // Memory cycle detect
   ////////////////////////////////////////////////////////////

   // Plain wait cycle, or conditional write from the dispatch ROM
   assign memEn = uWord.memCycle &
                  (uWord.memWait | (uWord.memBwrite & dWord.condFunc));

   // Dispatch ROM cycle bits
   assign dromCycle = dWord.readCycle | dWord.wrTestCycle | dWord.writeCycle;

   // Datapath decoded as a VMA word
   assign dpCycle = dp.read | dp.wrTest | dp.write;

   // Micro-word cycle bits
   assign cromCycle = uWord.readCycle | uWord.wrTestCycle | uWord.writeCycle;

   // Source priority
   // memAread picks the dispatch ROM ahead of the datapath
   always_comb
   begin
      if (!memEn)
      begin
         pfCycle = 1'b0;
      end
      else if (uWord.memAread)
      begin
         pfCycle = dromCycle;
      end
      else if (uWord.memDpFunc)
      begin
         pfCycle = dpCycle;
      end
      else
      begin
         pfCycle = cromCycle;
      end

      // A page-fail cycle only ever comes from a real bus request
      assert (!pfCycle || uWord.memCycle)
      else $error("pfCycle without memCycle");
   end

   ////////////////////////////////////////////////////////////
   // Fetch and memory clear
   ////////////////////////////////////////////////////////////

   // Interrupts are only taken at the instruction fetch
   assign fetchCycle = (uWord.uAddr == `KS_UADDR_FETCH);

   // Clears the page-fail dispatch
   assign memClr = uWord.specEn & (uWord.specSel == ks10Pkg::memClr);

endmodule

//--- source/ks10Pkg.sv
`include "ks10_defines.svh"

package ks10Pkg;

   ////////////////////////////////////////////////////////////
   // Enumerations
   ////////////////////////////////////////////////////////////

   // Page-fail dispatch codes, octal as in the microcode
   typedef enum logic [3:0]
   {
      none          = 4'o00,
      intr          = 4'o01,
      nxm           = 4'o05,
      writeFail     = 4'o10,
      timerPageFail = 4'o11,
      invalid       = 4'o12,
      mismatch      = 4'o13
   } dispCode;

   // Special-function select
   // Only memClr is decoded here
   typedef enum logic [2:0]
   {
      nop    = 3'd0,
      idle1  = 3'd1,
      idle2  = 3'd2,
      idle3  = 3'd3,
      memClr = 3'd4,
      idle5  = 3'd5,
      idle6  = 3'd6,
      idle7  = 3'd7
   } specFunc;

   ////////////////////////////////////////////////////////////
   // Control ROM and dispatch ROM subsets
   ////////////////////////////////////////////////////////////

   typedef struct packed
   {
      logic [`KS_UADDR_WIDTH-1:0] uAddr;
      // Bus cycle request
      logic memCycle;
      logic memWait;
      logic memBwrite;
      // Cycle type source select
      logic memAread;
      logic memDpFunc;
      // Cycle type from the micro-word itself
      logic readCycle;
      logic wrTestCycle;
      logic writeCycle;
      // Special function
      logic specEn;
      specFunc specSel;
   } microWord;

   typedef struct packed
   {
      logic condFunc;
      logic readCycle;
      logic wrTestCycle;
      logic writeCycle;
   } dispatchWord;

   ////////////////////////////////////////////////////////////
   // VMA layout, also used to decode the datapath
   ////////////////////////////////////////////////////////////

   typedef struct packed
   {
      logic [`KS_ADDR_WIDTH-`KS_PAGE_BITS-1:0] high;
      logic [`KS_PAGE_BITS-1:0] page;
   } vmaAddr;

   typedef struct packed
   {
      logic user;
      logic phys;
      logic acRef;
      logic read;
      logic wrTest;
      logic write;
      logic [`KS_VMA_PAD_WIDTH-1:0] padding;
      vmaAddr addr;
   } vmaWord;

   // One pager table entry
   typedef struct packed
   {
      logic valid;
      logic writeable;
      logic user;
      logic cacheable;
   } pageFlags;

endpackage

//--- source/ks10_defines.svh
`ifndef KS10_DEFINES_SVH
`define KS10_DEFINES_SVH

////////////////////////////////////////////////////////////
// Datapath and VMA sizes
////////////////////////////////////////////////////////////

// Full KS10 word
`define KS_WORD_WIDTH 36
// Word address carried in the low end of the VMA
`define KS_ADDR_WIDTH 18
// Unused bits between VMA flags and address
`define KS_VMA_PAD_WIDTH (`KS_WORD_WIDTH - `KS_ADDR_WIDTH - 6)

// Page number taken from the low end of the address
`define KS_PAGE_BITS 4
`define KS_PAGE_COUNT (1 << `KS_PAGE_BITS)

////////////////////////////////////////////////////////////
// Microcode
////////////////////////////////////////////////////////////

`define KS_UADDR_WIDTH 12
// Instruction fetch micro-address
`define KS_UADDR_FETCH 12'o0110

////////////////////////////////////////////////////////////
// APB register map
////////////////////////////////////////////////////////////

`define KS_APB_ADDR_WIDTH 8
`define KS_APB_DATA_WIDTH 32
// Page entry 0, one word per entry
`define KS_REG_PAGE_BASE 8'h00
// Bit 0 is paging enable
`define KS_REG_CONTROL 8'h40

`endif

//--- source/pagerTable.sv
`include "ks10_defines.svh"

module pagerTable
(
   input  logic                          clk,
   input  logic                          rst,
   // APB slave
   input  logic [`KS_APB_ADDR_WIDTH-1:0] paddr,
   input  logic                          psel,
   input  logic                          penable,
   input  logic                          pwrite,
   input  logic [`KS_APB_DATA_WIDTH-1:0] pwdata,
   output logic [`KS_APB_DATA_WIDTH-1:0] prdata,
   output logic                          pready,
   output logic                          pslverr,
   // Lookup
   input  ks10Pkg::vmaWord               vmaReg,
   output ks10Pkg::pageFlags             curFlags,
   output logic                          pageEnable
);

   ks10Pkg::pageFlags pageTab [`KS_PAGE_COUNT];

   logic [`KS_APB_ADDR_WIDTH-1:0] pageOffset;
   logic [`KS_PAGE_BITS-1:0]      pageIdx;
   logic                          pageHit;
   logic                          ctrlHit;
   logic                          access;
   logic                          wrEn;

   ////////////////////////////////////////////////////////////
   // Address decode
   ////////////////////////////////////////////////////////////

   // Byte offset into the page entry block
   assign pageOffset = paddr - `KS_REG_PAGE_BASE;
   assign pageIdx    = pageOffset[`KS_PAGE_BITS+1:2];

   // Word aligned and inside the block
   assign pageHit = (pageOffset[1:0] == 2'b00) &&
                    (pageOffset[`KS_APB_ADDR_WIDTH-1:`KS_PAGE_BITS+2] == '0);
   assign ctrlHit = (paddr == `KS_REG_CONTROL);

   // Access phase completes at once
   assign access = psel & penable;
   assign wrEn   = access & pwrite;

   // No wait states
   assign pready = 1'b1;

   // Unmapped address
   assign pslverr = access & ~(pageHit | ctrlHit);

   ////////////////////////////////////////////////////////////
   // Page table and control register
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         pageEnable <= 1'b0;
         for (int i = 0; i < `KS_PAGE_COUNT; i++)
         begin
            pageTab[i] <= '0;
         end
      end
      else if (wrEn)
      begin
         if (pageHit)
         begin
            // Low four bits hold the flags
            pageTab[pageIdx] <= ks10Pkg::pageFlags'(pwdata[$bits(ks10Pkg::pageFlags)-1:0]);
         end
         else if (ctrlHit)
         begin
            pageEnable <= pwdata[0];
         end
      end
   end

   // Read back, zero above the stored bits
   always_comb
   begin
      prdata = '0;
      if (pageHit)
      begin
         prdata[$bits(ks10Pkg::pageFlags)-1:0] = pageTab[pageIdx];
      end
      else if (ctrlHit)
      begin
         prdata[0] = pageEnable;
      end
   end

   // Lookup by VMA page number
   assign curFlags = pageTab[vmaReg.addr.page];

   ////////////////////////////////////////////////////////////
   // APB protocol checks
   ////////////////////////////////////////////////////////////

   apbEnableSel: assert property (@(posedge clk) disable iff (rst)
      penable |-> psel);

   // Setup phase fields carried into the access phase
   apbStable: assert property (@(posedge clk) disable iff (rst)
      (psel && !penable) |=> ($stable(paddr) && $stable(pwrite)));

endmodule

//--- source/pfDispatch.sv
module pfDispatch
(
   input  logic              clk,
   input  logic              rst,
   input  logic              clken,
   // From the cycle decoder
   input  logic              pfCycle,
   input  logic              fetchCycle,
   input  logic              memClr,
   // Address and pager state
   input  ks10Pkg::vmaWord   vmaReg,
   input  ks10Pkg::pageFlags curFlags,
   input  logic              pageEnable,
   // Interrupt sources
   input  logic              nxmIntr,
   input  logic              piIntr,
   input  logic              timerIntr,
   output logic              pageFail,
   output ks10Pkg::dispCode  dispPf
);

   logic pfEn;
   logic intrEn;
   logic pageCheck;
   logic pageInvalid;
   logic pageMismatch;
   logic pageWriteFail;

   ks10Pkg::dispCode dispNext;

   ////////////////////////////////////////////////////////////
   // Enables
   ////////////////////////////////////////////////////////////

   // One cycle after the bus request, never twice running
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         pfEn <= 1'b0;
      end
      else
      begin
         pfEn <= ~pfEn & pfCycle;
      end
   end

   // Interrupts are looked at just after the fetch
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         intrEn <= 1'b0;
      end
      else
      begin
         intrEn <= fetchCycle;
      end
   end

   ////////////////////////////////////////////////////////////
   // Failure classification
   ////////////////////////////////////////////////////////////

   // Physical and AC references bypass the pager
   assign pageCheck = pageEnable & ~vmaReg.phys & ~vmaReg.acRef;

   assign pageInvalid   = pageCheck & ~curFlags.valid;
   assign pageMismatch  = pageCheck & (vmaReg.user != curFlags.user);
   // Only a write test checks the writeable bit
   assign pageWriteFail = pageCheck & vmaReg.wrTest & ~curFlags.writeable;

   // Interrupts first, then page faults
   always_comb
   begin
      pageFail = 1'b1;
      if (intrEn && nxmIntr)
      begin
         dispNext = ks10Pkg::nxm;
      end
      else if (intrEn && piIntr)
      begin
         dispNext = ks10Pkg::intr;
      end
      else if (intrEn && timerIntr && pageInvalid)
      begin
         dispNext = ks10Pkg::timerPageFail;
      end
      else if (intrEn && timerIntr)
      begin
         dispNext = ks10Pkg::intr;
      end
      else if (pfEn && pageInvalid)
      begin
         dispNext = ks10Pkg::invalid;
      end
      else if (pfEn && pageMismatch)
      begin
         dispNext = ks10Pkg::mismatch;
      end
      else if (pfEn && pageWriteFail)
      begin
         dispNext = ks10Pkg::writeFail;
      end
      else
      begin
         pageFail = 1'b0;
         dispNext = ks10Pkg::none;
      end
   end

   ////////////////////////////////////////////////////////////
   // Dispatch register
   ////////////////////////////////////////////////////////////

   // Load wins over clear
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         dispPf <= ks10Pkg::none;
      end
      else if (clken && pageFail)
      begin
         dispPf <= dispNext;
      end
      else if (clken && memClr)
      begin
         dispPf <= ks10Pkg::none;
      end
   end

   failHasCode: assert property (@(posedge clk) disable iff (rst)
      pageFail |-> (dispNext != ks10Pkg::none));

   // Decoder and enable logic together keep this one cycle wide
   pfEnPulse: assert property (@(posedge clk) disable iff (rst)
      pfEn |=> !pfEn);

endmodule

//--- source/pfSubsystem.sv
`include "ks10_defines.svh"

module pfSubsystem
(
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          clken,
   // Per micro-instruction
   input  ks10Pkg::microWord             uWord,
   input  ks10Pkg::dispatchWord          dWord,
   input  ks10Pkg::vmaWord               dp,
   input  ks10Pkg::vmaWord               vmaReg,
   input  logic                          nxmIntr,
   input  logic                          piIntr,
   input  logic                          timerIntr,
   // APB slave
   input  logic [`KS_APB_ADDR_WIDTH-1:0] paddr,
   input  logic                          psel,
   input  logic                          penable,
   input  logic                          pwrite,
   input  logic [`KS_APB_DATA_WIDTH-1:0] pwdata,
   output logic [`KS_APB_DATA_WIDTH-1:0] prdata,
   output logic                          pready,
   output logic                          pslverr,
   // Dispatch
   output logic                          pageFail,
   output ks10Pkg::dispCode              dispPf
);

   // Decoder to dispatcher
   logic pfCycle;
   logic fetchCycle;
   logic memClr;

   // Pager to dispatcher
   ks10Pkg::pageFlags curFlags;
   logic              pageEnable;

   cycleDecode u_cycleDecode
   (
      .uWord      (uWord),
      .dWord      (dWord),
      .dp         (dp),
      .pfCycle    (pfCycle),
      .fetchCycle (fetchCycle),
      .memClr     (memClr)
   );

   pagerTable u_pagerTable
   (
      .clk        (clk),
      .rst        (rst),
      .paddr      (paddr),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .vmaReg     (vmaReg),
      .curFlags   (curFlags),
      .pageEnable (pageEnable)
   );

   pfDispatch u_pfDispatch
   (
      .clk        (clk),
      .rst        (rst),
      .clken      (clken),
      .pfCycle    (pfCycle),
      .fetchCycle (fetchCycle),
      .memClr     (memClr),
      .vmaReg     (vmaReg),
      .curFlags   (curFlags),
      .pageEnable (pageEnable),
      .nxmIntr    (nxmIntr),
      .piIntr     (piIntr),
      .timerIntr  (timerIntr),
      .pageFail   (pageFail),
      .dispPf     (dispPf)
   );

endmodule

//--- src.f
+incdir+source
source/ks10Pkg.sv
source/cycleDecode.sv
source/pagerTable.sv
source/pfDispatch.sv
source/pfSubsystem.sv
tests/pfTb.sv

//--- tests/pfTb.sv
`include "ks10_defines.svh"

module pfTb;

   // Twice the longest run of about 2000 cycles
   localparam int MaxCycles = 4000;

   logic                          clk;
   logic                          rst;
   logic                          clken;
   ks10Pkg::microWord             uWord;
   ks10Pkg::dispatchWord          dWord;
   ks10Pkg::vmaWord               dp;
   ks10Pkg::vmaWord               vmaReg;
   logic                          nxmIntr;
   logic                          piIntr;
   logic                          timerIntr;
   logic [`KS_APB_ADDR_WIDTH-1:0] paddr;
   logic                          psel;
   logic                          penable;
   logic                          pwrite;
   logic [`KS_APB_DATA_WIDTH-1:0] pwdata;
   logic [`KS_APB_DATA_WIDTH-1:0] prdata;
   logic                          pready;
   logic                          pslverr;
   logic                          pageFail;
   ks10Pkg::dispCode              dispPf;

   // Reference model state
   ks10Pkg::pageFlags mTab [`KS_PAGE_COUNT];
   logic              mEnable;
   logic              mPfEn;
   logic              mIntrEn;
   ks10Pkg::dispCode  mDisp;

   // Values seen just before the last edge
   logic                          lastPageFail;
   ks10Pkg::dispCode              lastDisp;
   logic [`KS_APB_DATA_WIDTH-1:0] lastPrdata;
   logic                          lastSlverr;

   int errorCount = 0;
   int cycleCount = 0;

   pfSubsystem u_pfSubsystem (.*);

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #10 clk = ~clk;
      end
   end

   always @(posedge clk)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= MaxCycles)
      begin
         $display("Timeout: the run went past %0d clock cycles", MaxCycles);
         $display("Test FAILED");
         $fatal(1, "timeout");
      end
   end

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   task automatic checkValue(input logic [31:0] expected, input logic [31:0] actual,
                             input string what);
      if (expected !== actual)
      begin
         errorCount++;
         $display("Mismatch at %0t: %s, expected %0h, got %0h",
                  $time, what, expected, actual);
         $display("Test FAILED");
         $fatal(1, "check failed");
      end
   endtask

   function automatic logic oneIn(input int n);
      return ($urandom % n) == 0;
   endfunction

   function automatic ks10Pkg::vmaWord randomVma();
      logic [63:0] r;
      r = {$urandom, $urandom};
      return r[`KS_WORD_WIDTH-1:0];
   endfunction

   // Never lands on the fetch address by chance
   function automatic ks10Pkg::microWord randomMicro();
      logic [31:0]       r;
      ks10Pkg::microWord w;
      r = $urandom;
      w = r[$bits(ks10Pkg::microWord)-1:0];
      if (w.uAddr == `KS_UADDR_FETCH)
         w.uAddr = '0;
      return w;
   endfunction

   // Waited bus cycle with its type from the micro-word
   function automatic ks10Pkg::microWord memoryMicro();
      ks10Pkg::microWord w;
      w = randomMicro();
      w.memCycle  = 1'b1;
      w.memWait   = 1'b1;
      w.memAread  = 1'b0;
      w.memDpFunc = 1'b0;
      if (!(w.readCycle | w.wrTestCycle | w.writeCycle))
         w.readCycle = 1'b1;
      return w;
   endfunction

   function automatic logic [`KS_APB_ADDR_WIDTH-1:0] pageAddr(input int idx);
      return `KS_REG_PAGE_BASE + 8'(idx * 4);
   endfunction

   // Inside the page block and word aligned
   function automatic logic isPageReg(input logic [`KS_APB_ADDR_WIDTH-1:0] a);
      logic [`KS_APB_ADDR_WIDTH-1:0] off;
      off = a - `KS_REG_PAGE_BASE;
      return (off[1:0] == 2'b00) && (32'(off) < 4 * `KS_PAGE_COUNT);
   endfunction

   // Interrupts at fetch outrank page faults
   function automatic ks10Pkg::dispCode expectedCode(input logic intrOn, input logic pfOn,
      input logic badValid, input logic badUser, input logic badWrite);
      if (intrOn && nxmIntr)
         return ks10Pkg::nxm;
      if (intrOn && piIntr)
         return ks10Pkg::intr;
      if (intrOn && timerIntr)
         return badValid ? ks10Pkg::timerPageFail : ks10Pkg::intr;
      if (pfOn && badValid)
         return ks10Pkg::invalid;
      if (pfOn && badUser)
         return ks10Pkg::mismatch;
      if (pfOn && badWrite)
         return ks10Pkg::writeFail;
      return ks10Pkg::none;
   endfunction

   ////////////////////////////////////////////////////////////
   // Compare before the edge and then advance the model
   ////////////////////////////////////////////////////////////

   task automatic runCycle();
      logic                          memEn;
      logic                          srcAny;
      logic                          pfCycleM;
      logic                          memClrM;
      logic                          pageOn;
      logic                          pageHitM;
      logic                          ctrlHitM;
      logic                          access;
      logic [`KS_PAGE_BITS-1:0]      idx;
      logic [`KS_APB_DATA_WIDTH-1:0] expRd;
      ks10Pkg::pageFlags             flags;
      ks10Pkg::dispCode              codeM;
      #16;
      lastPageFail = pageFail;
      lastDisp     = dispPf;
      lastPrdata   = prdata;
      lastSlverr   = pslverr;

      // Bus cycle type from the selected source
      memEn  = uWord.memCycle && (uWord.memWait || (uWord.memBwrite && dWord.condFunc));
      srcAny = uWord.memAread ? (dWord.readCycle | dWord.wrTestCycle | dWord.writeCycle)
             : uWord.memDpFunc ? (dp.read | dp.wrTest | dp.write)
             : (uWord.readCycle | uWord.wrTestCycle | uWord.writeCycle);
      pfCycleM = memEn && srcAny;
      memClrM  = uWord.specEn && (uWord.specSel == ks10Pkg::memClr);

      // Pager checks
      flags  = mTab[vmaReg.addr.page];
      pageOn = mEnable && !vmaReg.phys && !vmaReg.acRef;
      codeM  = expectedCode(mIntrEn, mPfEn, pageOn && !flags.valid,
                            pageOn && (vmaReg.user != flags.user),
                            pageOn && vmaReg.wrTest && !flags.writeable);
      checkValue(32'(codeM != ks10Pkg::none), 32'(pageFail), "pageFail");
      checkValue(32'(mDisp), 32'(dispPf), "dispPf register");

      // APB side
      access   = psel && penable;
      pageHitM = isPageReg(paddr);
      ctrlHitM = (paddr == `KS_REG_CONTROL);
      idx      = paddr[`KS_PAGE_BITS+1:2];
      expRd    = '0;
      if (pageHitM)
         expRd[$bits(ks10Pkg::pageFlags)-1:0] = mTab[idx];
      else if (ctrlHitM)
         expRd[0] = mEnable;
      checkValue(32'd1, 32'(pready), "pready");
      checkValue(32'(access && !(pageHitM || ctrlHitM)), 32'(pslverr), "pslverr");
      if (access && !pwrite && (pageHitM || ctrlHitM))
         checkValue(expRd, prdata, "prdata");

      // State at the coming edge
      if (clken && (codeM != ks10Pkg::none))
         mDisp = codeM;
      else if (clken && memClrM)
         mDisp = ks10Pkg::none;
      mPfEn   = !mPfEn && pfCycleM;
      mIntrEn = (uWord.uAddr == `KS_UADDR_FETCH);
      if (access && pwrite && pageHitM)
         mTab[idx] = pwdata[$bits(ks10Pkg::pageFlags)-1:0];
      else if (access && pwrite && ctrlHitM)
         mEnable = pwdata[0];

      @(posedge clk);
      #2;
   endtask

   // Setup then access with the bus left idle after
   task automatic apbTransfer(input logic [`KS_APB_ADDR_WIDTH-1:0] addr, input logic wr,
                              input logic [`KS_APB_DATA_WIDTH-1:0] data);
      paddr   = addr;
      pwrite  = wr;
      pwdata  = data;
      psel    = 1'b1;
      penable = 1'b0;
      runCycle();
      penable = 1'b1;
      runCycle();
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic idleInputs();
      clken     = 1'b1;
      uWord     = '0;
      dWord     = '0;
      dp        = '0;
      nxmIntr   = 1'b0;
      piIntr    = 1'b0;
      timerIntr = 1'b0;
   endtask

   task automatic scrambleInputs();
      logic [31:0] r;
      uWord = randomMicro();
      if (oneIn(8))
         uWord.uAddr = `KS_UADDR_FETCH;
      if (oneIn(2))
         uWord.specSel = ks10Pkg::memClr;
      r            = $urandom;
      dWord        = r[3:0];
      dp           = randomVma();
      vmaReg       = randomVma();
      vmaReg.phys  = oneIn(4);
      vmaReg.acRef = oneIn(4);
      nxmIntr      = oneIn(4);
      piIntr       = oneIn(4);
      timerIntr    = oneIn(4);
   endtask

   ////////////////////////////////////////////////////////////
   // Test sections
   ////////////////////////////////////////////////////////////

   task automatic loadAndReadBack();
      logic [`KS_APB_DATA_WIDTH-1:0] written [`KS_PAGE_COUNT];
      logic [`KS_APB_DATA_WIDTH-1:0] ctrlValue;
      logic [`KS_APB_ADDR_WIDTH-1:0] badAddr;
      logic [`KS_PAGE_BITS-1:0]      aliasIdx;
      for (int i = 0; i < `KS_PAGE_COUNT; i++)
      begin
         written[i] = $urandom;
         apbTransfer(pageAddr(i), 1'b1, written[i]);
      end
      ctrlValue = $urandom;
      apbTransfer(`KS_REG_CONTROL, 1'b1, ctrlValue);
      for (int i = 0; i < `KS_PAGE_COUNT; i++)
      begin
         apbTransfer(pageAddr(i), 1'b0, '0);
         checkValue(written[i] & 32'hF, lastPrdata, "page entry readback");
         checkValue(32'd0, 32'(lastSlverr), "pslverr on page entry");
      end
      apbTransfer(`KS_REG_CONTROL, 1'b0, '0);
      checkValue(ctrlValue & 32'h1, lastPrdata, "control readback");
      // Any address outside the map
      do
         badAddr = 8'($urandom);
      while (isPageReg(badAddr) || badAddr == `KS_REG_CONTROL);
      aliasIdx = badAddr[`KS_PAGE_BITS+1:2];
      apbTransfer(badAddr, 1'b1, $urandom);
      checkValue(32'd1, 32'(lastSlverr), "pslverr on unmapped write");
      apbTransfer(badAddr, 1'b0, '0);
      checkValue(32'd1, 32'(lastSlverr), "pslverr on unmapped read");
      // Entry that the unmapped address would alias onto
      apbTransfer(pageAddr(int'(aliasIdx)), 1'b0, '0);
      checkValue(written[aliasIdx] & 32'hF, lastPrdata, "entry after unmapped write");
   endtask

   task automatic classifyFaults();
      logic [31:0]       r;
      logic [3:0]        idx;
      ks10Pkg::vmaWord   vma;
      apbTransfer(`KS_REG_CONTROL, 1'b1, 32'h1);
      for (int iter = 0; iter < 150; iter++)
      begin
         r   = $urandom;
         idx = r[3:0];
         apbTransfer(pageAddr(int'(idx)), 1'b1, $urandom);
         // Paging off now and then
         if (iter % 16 == 15)
            apbTransfer(`KS_REG_CONTROL, 1'b1, 32'(!oneIn(4)));
         vma           = randomVma();
         vma.phys      = oneIn(4);
         vma.acRef     = oneIn(4);
         vma.addr.page = idx;
         vmaReg        = vma;
         uWord         = memoryMicro();
         runCycle();
         // Fault shows here
         idleInputs();
         runCycle();
      end
   endtask

   task automatic sourceSelect();
      logic [31:0] r;
      apbTransfer(`KS_REG_CONTROL, 1'b1, 32'h1);
      for (int i = 0; i < `KS_PAGE_COUNT; i++)
         apbTransfer(pageAddr(i), 1'b1, '0);
      // Every page invalid so pageFail mirrors pfEn
      vmaReg       = randomVma();
      vmaReg.phys  = 1'b0;
      vmaReg.acRef = 1'b0;
      for (int iter = 0; iter < 300; iter++)
      begin
         uWord          = randomMicro();
         uWord.memCycle = !oneIn(4);
         r              = $urandom;
         dWord          = r[3:0];
         dp             = randomVma();
         runCycle();
      end
      idleInputs();
      runCycle();
      runCycle();
      // Back-to-back memory micro-instructions
      uWord = memoryMicro();
      for (int i = 0; i < 8; i++)
      begin
         runCycle();
         checkValue(32'(i % 2), 32'(lastPageFail), "pfEn on alternate cycles");
      end
      idleInputs();
      runCycle();
   endtask

   task automatic interruptPriority();
      // Odd pages valid and even pages invalid
      for (int i = 0; i < `KS_PAGE_COUNT; i++)
         apbTransfer(pageAddr(i), 1'b1, (i % 2 == 1) ? 32'hE : 32'h6);
      for (int iter = 0; iter < 200; iter++)
      begin
         uWord          = randomMicro();
         uWord.uAddr    = `KS_UADDR_FETCH;
         uWord.memCycle = oneIn(2);
         vmaReg         = randomVma();
         vmaReg.phys    = oneIn(8);
         vmaReg.acRef   = oneIn(8);
         nxmIntr        = oneIn(3);
         piIntr         = oneIn(3);
         timerIntr      = oneIn(3);
         runCycle();
         // Interrupts sampled here
         uWord.uAddr    = '0;
         uWord.memCycle = 1'b0;
         nxmIntr        = oneIn(3);
         piIntr         = oneIn(3);
         timerIntr      = oneIn(3);
         runCycle();
      end
      idleInputs();
      runCycle();
   endtask

   task automatic dispatchRegister();
      ks10Pkg::dispCode heldCode;
      int               holdLen;
      for (int iter = 0; iter < 400; iter++)
      begin
         if (oneIn(32))
         begin
            // Several cycles with clken low
            holdLen = 3 + int'($urandom % 4);
            scrambleInputs();
            clken = 1'b0;
            runCycle();
            heldCode = lastDisp;
            repeat (holdLen)
            begin
               scrambleInputs();
               clken = 1'b0;
               runCycle();
               checkValue(32'(heldCode), 32'(lastDisp), "dispPf hold with clken low");
            end
         end
         scrambleInputs();
         clken = !oneIn(4);
         runCycle();
      end
      idleInputs();
      runCycle();
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////

   initial
   begin
      void'($urandom(78));
      rst     = 1'b1;
      vmaReg  = '0;
      paddr   = '0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      pwdata  = '0;
      idleInputs();
      clken   = 1'b0;

      // Model starts from reset
      for (int i = 0; i < `KS_PAGE_COUNT; i++)
         mTab[i] = '0;
      mEnable = 1'b0;
      mPfEn   = 1'b0;
      mIntrEn = 1'b0;
      mDisp   = ks10Pkg::none;

      repeat (10) @(posedge clk);
      #2;
      rst = 1'b0;
      idleInputs();
      runCycle();

      loadAndReadBack();
      classifyFaults();
      sourceSelect();
      interruptPriority();
      dispatchRegister();

      if (errorCount == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule
